/* src.f */
+incdir+common
common/icache_pkg.sv
icache/icache_tag_store.sv
icache/icache_data_store.sv
icache/icache_victim_select.sv
icache/icache_ctrl.sv
source/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the icache testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1

/* testbench/icache_tb.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_tb
    import icache_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 10;
    localparam int IMAGE_WORDS  = 1024;
    localparam int NUM_FETCHES  = 25;
    localparam int WORST_CYCLES = 32;   // slowest miss plus margin
    localparam int WATCHDOG_NS  = (RESET_CYCLES + 20 + NUM_FETCHES * WORST_CYCLES) * CLK_PERIOD;
    localparam int OFF_LSB      = `ICACHE_BYTE_W;
    localparam int SET_LSB      = OFF_LSB + `ICACHE_OFF_W;
    localparam int TAG_LSB      = SET_LSB + `ICACHE_SET_W;
    localparam int EXPECT_HIT   = 0;
    localparam int EXPECT_MISS  = 1;
    localparam int EXPECT_ANY   = 2;

    logic  Clk;
    logic  rst;
    logic  read_en;
    addr_t read_addr;
    word_t instruction;
    logic  ready;
    logic  busy;
    logic  mem_req;
    addr_t mem_addr;
    word_t mem_data;
    logic  mem_data_valid;

    addr_t exp_q [$];        // accepted fetches waiting for ready
    addr_t cur_addr  = '0;
    int    fetch_cnt = 0;
    int    ready_cnt = 0;
    int    err_data  = 0;
    int    err_req   = 0;
    int    err_ctrl  = 0;

    icache_top dut_i (
        .Clk            (Clk),
        .rst            (rst),
        .read_en        (read_en),
        .read_addr      (read_addr),
        .instruction    (instruction),
        .ready          (ready),
        .busy           (busy),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid)
    );

    icache_mem_model mem_i (
        .Clk            (Clk),
        .rst            (rst),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid)
    );

    initial Clk = 1'b0;
    always #(CLK_PERIOD / 2) Clk = ~Clk;

    // expected word at a byte address, hashed from the word index
    function automatic word_t ref_word(input addr_t addr);
        word_t h;
        h = {2'b00, addr[31:2]} ^ 32'h5bd1_e995;
        h = h * 32'h9e37_79b1;
        h = h ^ (h >> 13);
        h = h + {addr[15:0], addr[31:16]};
        return h;
    endfunction

    function automatic addr_t make_addr(input int tag, input int set_idx, input int off);
        return (addr_t'(tag) << TAG_LSB) | (addr_t'(set_idx) << SET_LSB)
             | (addr_t'(off) << OFF_LSB);
    endfunction

    // one fetch from a drive point, optionally strobing read_en while busy
    task automatic fetch(input addr_t addr, input int expect_kind, input bit strobe_busy,
                         output bit missed);
        int lat;
        int reqs;
        while (busy) begin
            @(posedge Clk);
            #DRIVE_DELAY;
        end
        cur_addr = addr;
        fetch_cnt++;
        exp_q.push_back(addr);
        read_en   = 1'b1;
        read_addr = addr;
        @(posedge Clk);   // accepting edge
        #DRIVE_DELAY;
        read_en = 1'b0;
        lat     = 1;
        reqs    = mem_req ? 1 : 0;
        if (mem_req && !busy) begin
            $display("fetch of %h sent a memory request without raising busy", addr);
            err_ctrl++;
        end
        while (!ready) begin
            if (strobe_busy && busy) begin
                read_en   = 1'b1;
                read_addr = addr ^ (addr_t'(1) << TAG_LSB);   // other tag, must be dropped
            end
            @(posedge Clk);
            #DRIVE_DELAY;
            read_en = 1'b0;
            lat++;
            if (mem_req) begin
                reqs++;
            end
        end
        missed = (reqs != 0);
        if (reqs > 1) begin
            $display("fetch of %h issued %0d memory requests", addr, reqs);
            err_ctrl++;
        end
        if (busy) begin
            $display("busy still high when fetch of %h returned", addr);
            err_ctrl++;
        end
        if (expect_kind == EXPECT_HIT && (missed || lat != 1)) begin
            $display("fetch of %h should hit in one cycle but took %0d cycles", addr, lat);
            err_ctrl++;
        end
        if (expect_kind == EXPECT_MISS && !missed) begin
            $display("fetch of %h should miss but sent no memory request", addr);
            err_ctrl++;
        end
    endtask

    // compare each returned instruction with the oldest accepted fetch
    always @(negedge Clk) begin : check_ready
        addr_t a;
        if (!rst && ready) begin
            ready_cnt++;
            if (exp_q.size() == 0) begin
                $display("ready pulsed with no fetch outstanding");
                err_data++;
            end else begin
                a = exp_q.pop_front();
                if (instruction !== ref_word(a)) begin
                    $display("ERR instruction: addr %h expected %h got %h",
                             a, ref_word(a), instruction);
                    err_data++;
                end
            end
        end
    end

    always @(negedge Clk) begin
        if (!rst && mem_req) begin
            if (mem_addr !== (cur_addr & ~addr_t'(`ICACHE_BLOCK_WORDS * 4 - 1))) begin
                $display("ERR mem_addr: expected %h got %h",
                         cur_addr & ~addr_t'(`ICACHE_BLOCK_WORDS * 4 - 1), mem_addr);
                err_req++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired: fetch %0d at address %h never returned", fetch_cnt, cur_addr);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : main
        bit missed;
        int reread_misses;
        read_en   = 1'b0;
        read_addr = '0;
        rst       = 1'b1;
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            mem_i.image[i] = ref_word(addr_t'(i * 4));
        end
        repeat (RESET_CYCLES) @(posedge Clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        if (ready !== 1'b0) begin
            $display("ERR ready: expected %h got %h", 1'b0, ready);
            err_ctrl++;
        end
        if (busy !== 1'b0) begin
            $display("ERR busy: expected %h got %h", 1'b0, busy);
            err_ctrl++;
        end
        if (mem_req !== 1'b0) begin
            $display("ERR mem_req: expected %h got %h", 1'b0, mem_req);
            err_ctrl++;
        end

        // cold miss, then every word of the filled block hits
        fetch(make_addr(1, 2, 1), EXPECT_MISS, 1'b0, missed);
        for (int off = 0; off < 4; off++) begin
            fetch(make_addr(1, 2, off), EXPECT_HIT, 1'b0, missed);
        end

        // critical word at each offset
        fetch(make_addr(3, 5, 0), EXPECT_MISS, 1'b0, missed);
        fetch(make_addr(3, 6, 1), EXPECT_MISS, 1'b0, missed);
        fetch(make_addr(3, 7, 2), EXPECT_MISS, 1'b0, missed);
        fetch(make_addr(3, 0, 3), EXPECT_MISS, 1'b0, missed);

        // four tags into set 1 fill all ways
        for (int t = 4; t < 8; t++) begin
            fetch(make_addr(t, 1, t % 4), EXPECT_MISS, 1'b0, missed);
        end
        for (int t = 4; t < 8; t++) begin
            fetch(make_addr(t, 1, t % 4), EXPECT_HIT, 1'b0, missed);
        end

        // fifth tag evicts one of them
        fetch(make_addr(8, 1, 2), EXPECT_MISS, 1'b0, missed);
        fetch(make_addr(8, 1, 2), EXPECT_HIT, 1'b0, missed);
        reread_misses = 0;
        for (int t = 4; t < 9; t++) begin
            fetch(make_addr(t, 1, t % 4), EXPECT_ANY, 1'b0, missed);
            if (missed) begin
                reread_misses++;
            end
        end
        if (reread_misses == 0) begin
            $display("five tags in a four-way set were re-read without a single miss");
            err_ctrl++;
        end

        // strobes during a refill must be ignored
        fetch(make_addr(9, 4, 3), EXPECT_MISS, 1'b1, missed);

        repeat (4) @(posedge Clk);
        if (exp_q.size() != 0 || ready_cnt != fetch_cnt) begin
            $display("%0d fetches accepted but %0d ready pulses seen", fetch_cnt, ready_cnt);
            err_ctrl++;
        end
        $display("errors: data %0d, memory request %0d, control %0d",
                 err_data, err_req, err_ctrl);
        if (err_data == 0 && err_req == 0 && err_ctrl == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/icache_mem_model.sv */
`timescale 1ns/10ps

module icache_mem_model
    import icache_pkg::*;
(
    input  logic  Clk,
    input  logic  rst,
    input  logic  mem_req,
    input  addr_t mem_addr,
    output word_t mem_data,
    output logic  mem_data_valid
);

    localparam int IMAGE_WORDS = 1024;
    localparam int DRIVE_DELAY = 5;   // ns after the rising edge

    word_t image [IMAGE_WORDS];   // loaded by the testbench before reset ends

    initial begin : serve
        addr_t base;
        int    delay;
        int    gap;
        int    idx;
        mem_data       = '0;
        mem_data_valid = 1'b0;
        void'($urandom(32'h829a5189));
        forever begin
            @(posedge Clk);
            #DRIVE_DELAY;
            if (!rst && mem_req) begin
                base  = mem_addr;
                delay = 1 + int'($urandom % 6);   // request to first word
                repeat (delay) begin
                    @(posedge Clk);
                    #DRIVE_DELAY;
                end
                for (int w = 0; w < `ICACHE_BLOCK_WORDS; w++) begin
                    idx            = (int'(base[31:2]) + w) % IMAGE_WORDS;
                    mem_data       = image[idx];
                    mem_data_valid = 1'b1;
                    @(posedge Clk);
                    #DRIVE_DELAY;
                    mem_data_valid = 1'b0;
                    mem_data       = '0;
                    if (w < `ICACHE_BLOCK_WORDS - 1) begin
                        gap = int'($urandom % 3);   // idle cycles between words
                        repeat (gap) begin
                            @(posedge Clk);
                            #DRIVE_DELAY;
                        end
                    end
                end
            end
        end
    end

endmodule

/* source/icache_top.sv */
`timescale 1ns/10ps

module icache_top
    import icache_pkg::*;
(
    input  logic  Clk,
    input  logic  rst,

    // fetch side
    input  logic  read_en,
    input  addr_t read_addr,
    output word_t instruction,
    output logic  ready,
    output logic  busy,

    // burst memory side
    output logic  mem_req,
    output addr_t mem_addr,
    input  word_t mem_data,
    input  logic  mem_data_valid
);

    set_idx_t  lookup_set;
    tag_t      lookup_tag;
    logic      hit;
    way_idx_t  hit_way;
    way_mask_t set_valid;
    way_idx_t  victim_way;
    way_idx_t  rd_way;
    word_off_t rd_off;
    word_t     rd_word;
    data_wr_t  data_wr;
    tag_wr_t   tag_wr;

    icache_ctrl ctrl_i (
        .Clk            (Clk),
        .rst            (rst),
        .read_en        (read_en),
        .read_addr      (read_addr),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .rd_word        (rd_word),
        .mem_data       (mem_data),
        .mem_data_valid (mem_data_valid),
        .lookup_set     (lookup_set),
        .lookup_tag     (lookup_tag),
        .rd_way         (rd_way),
        .rd_off         (rd_off),
        .data_wr        (data_wr),
        .tag_wr         (tag_wr),
        .instruction    (instruction),
        .ready          (ready),
        .busy           (busy),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr)
    );

    icache_tag_store tag_store_i (
        .Clk        (Clk),
        .rst        (rst),
        .lookup_set (lookup_set),
        .lookup_tag (lookup_tag),
        .tag_wr     (tag_wr),
        .hit        (hit),
        .hit_way    (hit_way),
        .set_valid  (set_valid)
    );

    // data read uses the same set as the tag lookup
    icache_data_store data_store_i (
        .Clk     (Clk),
        .data_wr (data_wr),
        .rd_set  (lookup_set),
        .rd_way  (rd_way),
        .rd_off  (rd_off),
        .rd_word (rd_word)
    );

    icache_victim_select victim_i (
        .Clk        (Clk),
        .rst        (rst),
        .set_valid  (set_valid),
        .victim_way (victim_way)
    );

endmodule

/* icache/icache_ctrl.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic      Clk,
    input  logic      rst,
    input  logic      read_en,
    input  addr_t     read_addr,
    input  logic      hit,
    input  way_idx_t  hit_way,
    input  way_idx_t  victim_way,
    input  word_t     rd_word,
    input  word_t     mem_data,
    input  logic      mem_data_valid,
    output set_idx_t  lookup_set,
    output tag_t      lookup_tag,
    output way_idx_t  rd_way,
    output word_off_t rd_off,
    output data_wr_t  data_wr,
    output tag_wr_t   tag_wr,
    output word_t     instruction,
    output logic      ready,
    output logic      busy,
    output logic      mem_req,
    output addr_t     mem_addr
);

    localparam word_off_t LAST_OFF = word_off_t'(`ICACHE_BLOCK_WORDS - 1);

    refill_state_t state;
    fetch_addr_t   fa;          // decoded incoming fetch
    fetch_addr_t   blk_addr;
    fetch_addr_t   req;         // address of the miss in flight
    way_idx_t      fill_way;
    word_off_t     cnt;         // refill word counter
    word_t         crit_word;
    logic          accept;

    assign fa     = fetch_addr_t'(read_addr);
    assign busy   = (state != RF_IDLE);
    assign accept = read_en && (state == RF_IDLE);   // strobes while busy are dropped

    // lookup straight off the fetch address
    assign lookup_set = fa.set_idx;
    assign lookup_tag = fa.tag;
    assign rd_way     = hit_way;
    assign rd_off     = fa.off;

    always_comb begin
        blk_addr          = fa;
        blk_addr.off      = '0;
        blk_addr.byte_off = '0;
    end

    // refill writes go straight into the array as they arrive
    always_comb begin
        data_wr.en      = (state == RF_WAIT) && mem_data_valid;
        data_wr.set_idx = req.set_idx;
        data_wr.way     = fill_way;
        data_wr.off     = cnt;
        data_wr.word    = mem_data;

        tag_wr.en      = data_wr.en && (cnt == LAST_OFF);   // with the last word
        tag_wr.set_idx = req.set_idx;
        tag_wr.way     = fill_way;
        tag_wr.tag     = req.tag;
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            state   <= RF_IDLE;
            ready   <= 1'b0;
            mem_req <= 1'b0;
            cnt     <= '0;
        end else begin
            ready   <= 1'b0;
            mem_req <= 1'b0;
            case (state)
                RF_IDLE: begin
                    if (accept) begin
                        if (hit) begin
                            ready <= 1'b1;
                        end else begin
                            mem_req <= 1'b1;
                            cnt     <= '0;
                            state   <= RF_WAIT;
                        end
                    end
                end
                RF_WAIT: begin
                    if (mem_data_valid) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == LAST_OFF) begin
                            state <= RF_DONE;
                        end
                    end
                end
                RF_DONE: begin
                    ready <= 1'b1;   // critical word goes out now
                    state <= RF_IDLE;
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept && !hit) begin
            req      <= fa;
            fill_way <= victim_way;
            mem_addr <= addr_t'(blk_addr);
        end
        if (data_wr.en && cnt == req.off) begin
            crit_word <= mem_data;
        end
        if (accept && hit) begin
            instruction <= rd_word;
        end else if (state == RF_DONE) begin
            instruction <= crit_word;
        end
    end

endmodule

/* icache/icache_victim_select.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_victim_select
    import icache_pkg::*;
(
    input  logic      Clk,
    input  logic      rst,
    input  way_mask_t set_valid,
    output way_idx_t  victim_way
);

    localparam logic [7:0] LFSR_SEED = 8'hA5;

    logic [7:0] lfsr;
    logic       lfsr_fb;
    logic       any_invalid;
    way_idx_t   first_invalid;

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    always_ff @(posedge Clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};   // free running
        end
    end

    assign any_invalid = ~&set_valid;

    // scan downwards so the lowest invalid way wins
    always_comb begin
        first_invalid = '0;
        for (int w = `ICACHE_NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                first_invalid = way_idx_t'(w);
            end
        end
    end

    assign victim_way = any_invalid ? first_invalid : lfsr[`ICACHE_WAY_W-1:0];

endmodule

/* icache/icache_data_store.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_data_store
    import icache_pkg::*;
(
    input  logic      Clk,
    input  data_wr_t  data_wr,
    input  set_idx_t  rd_set,
    input  way_idx_t  rd_way,
    input  word_off_t rd_off,
    output word_t     rd_word
);

    // set x way x word
    word_t words [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS][`ICACHE_BLOCK_WORDS];

    always_ff @(posedge Clk) begin
        if (data_wr.en) begin
            words[data_wr.set_idx][data_wr.way][data_wr.off] <= data_wr.word;
        end
    end

    // async read, hit data is registered by the controller
    assign rd_word = words[rd_set][rd_way][rd_off];

endmodule

/* icache/icache_tag_store.sv */
`timescale 1ns/10ps
`include "icache_cfg.svh"

module icache_tag_store
    import icache_pkg::*;
(
    input  logic      Clk,
    input  logic      rst,
    input  set_idx_t  lookup_set,
    input  tag_t      lookup_tag,
    input  tag_wr_t   tag_wr,
    output logic      hit,
    output way_idx_t  hit_way,
    output way_mask_t set_valid
);

    tag_t      tags  [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
    way_mask_t valid [`ICACHE_NUM_SETS];

    // a commit sets one valid bit
    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (tag_wr.en) begin
            valid[tag_wr.set_idx][tag_wr.way] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (tag_wr.en) begin
            tags[tag_wr.set_idx][tag_wr.way] <= tag_wr.tag;
        end
    end

    assign set_valid = valid[lookup_set];

    // parallel compare over all ways of the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
            if (!hit && set_valid[w] && tags[lookup_set][w] == lookup_tag) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(w);
            end
        end
    end

endmodule

/* common/icache_pkg.sv */
`include "icache_cfg.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]   addr_t;
    typedef logic [`ICACHE_WORD_W-1:0]   word_t;
    typedef logic [`ICACHE_TAG_W-1:0]    tag_t;
    typedef logic [`ICACHE_SET_W-1:0]    set_idx_t;
    typedef logic [`ICACHE_WAY_W-1:0]    way_idx_t;
    typedef logic [`ICACHE_OFF_W-1:0]    word_off_t;
    typedef logic [`ICACHE_NUM_WAYS-1:0] way_mask_t;

    // fetch address split into its fields, msb first
    typedef struct packed {
        tag_t                      tag;
        set_idx_t                  set_idx;
        word_off_t                 off;
        logic [`ICACHE_BYTE_W-1:0] byte_off;   // not used by the cache
    } fetch_addr_t;

    // one refill word going into the data array
    typedef struct packed {
        logic      en;
        set_idx_t  set_idx;
        way_idx_t  way;
        word_off_t off;
        word_t     word;
    } data_wr_t;

    // tag commit at the end of a refill
    typedef struct packed {
        logic     en;
        set_idx_t set_idx;
        way_idx_t way;
        tag_t     tag;
    } tag_wr_t;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_WAIT,
        RF_DONE
    } refill_state_t;

endpackage

/* common/icache_cfg.svh */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// cache geometry
`define ICACHE_NUM_SETS     8
`define ICACHE_NUM_WAYS     4
`define ICACHE_BLOCK_WORDS  4   // 32-bit words per block

// address and word widths
`define ICACHE_ADDR_W       32
`define ICACHE_WORD_W       32

// derived field widths
`define ICACHE_SET_W        $clog2(`ICACHE_NUM_SETS)
`define ICACHE_WAY_W        $clog2(`ICACHE_NUM_WAYS)
`define ICACHE_OFF_W        $clog2(`ICACHE_BLOCK_WORDS)
`define ICACHE_BYTE_W       2   // byte offset inside a word

// tag is whatever remains above set index and offsets
`define ICACHE_TAG_W \
    (`ICACHE_ADDR_W - `ICACHE_SET_W - `ICACHE_OFF_W - `ICACHE_BYTE_W)

`endif
